//--- upsampler_tests.txt
// columns: op ch count value_a value_b, all hex
// op 1 writes value_a to ch, op 2 pops ch count times expecting value_a, op 3 pops both, op 0 ends
1 0 0 400000 000000   // impulse into channel 0
1 1 0 7fffff 000000   // channel 1 gets two positive then two negative full-scale samples
1 1 0 7fffff 000000
1 1 0 800000 000000
1 1 0 800000 000000
3 0 1 000000 000000   // first pops after reset return the reset result
3 0 a 000000 000000   // samples not yet inside the tap window
2 0 1 ff6d00 000000   // channel 0 impulse response, phase 0 and phase 1 taps in turn
2 0 1 ffae00 000000
2 0 1 01f580 000000
2 0 1 012e80 000000
2 0 1 f9c500 000000
2 0 1 fc9b00 000000
2 0 1 397500 000000
2 0 2 0e6600 000000
2 1 1 feda00 000000   // channel 1 results computed alongside channel 0
2 1 1 ff5c00 000000
2 1 1 02c4ff 000000
2 1 1 01b8ff 000000
2 1 1 f89aff 000000
2 1 1 fc36ff 000000
2 1 1 63aeff 000000
2 1 1 1448ff 000000
2 1 2 7fffff 000000   // positive saturation on both phases
2 1 1 af8dff 000000
2 1 1 5071ff 000000
2 1 1 800001 000000   // negative saturation
0 0 0 000000 000000

//--- src.f
resampler_pkg.sv
sample_ringbuf.sv
fir_coeff_rom.sv
shared_multiplier.sv
polyphase_channel.sv
multiplier_grant.sv
upsampler_stereo.sv
upsampler_stereo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= upsampler_stereo_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- upsampler_stereo_tb.sv
// testbench for the stereo upsampler, replays upsampler_tests.txt and checks every output ack
`timescale 1ns/100ps

module upsampler_stereo_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int MAX_LINES = 64;
    // hex words per line of the data file
    localparam int LINE_WORDS = 5;

    localparam int OP_END = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_POP = 2;
    localparam int OP_POP_BOTH = 3;

    logic                               clk;
    logic                               rst;
    logic [resampler_pkg::SAMPLE_W-1:0] data_i;
    logic [1:0]                         wr_ack_i;
    logic [1:0]                         rd_pop_o;
    logic [1:0]                         out_pop_i;
    logic [resampler_pkg::SAMPLE_W-1:0] data_o;
    logic [1:0]                         out_ack_o;

    logic [31:0] test_mem [MAX_LINES*LINE_WORDS];
    int          pop_count [2];
    int          rd_pop_count [2];

    upsampler_stereo upsampler_stereo_inst (
        .clk       (clk),
        .rst       (rst),
        .data_i    (data_i),
        .wr_ack_i  (wr_ack_i),
        .rd_pop_o  (rd_pop_o),
        .out_pop_i (out_pop_i),
        .data_o    (data_o),
        .out_ack_o (out_ack_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // producer side pulses, sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (rd_pop_o[ch]) begin
                    rd_pop_count[ch] = rd_pop_count[ch] + 1;
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_sample(input int ch, input logic [31:0] sample);
        data_i = sample[resampler_pkg::SAMPLE_W-1:0];
        wr_ack_i[ch] = 1'b1;
        step_cycle();
        wr_ack_i = '0;
        data_i = '0;
    endtask

    // busy flag rises once the grant arrives and falls after the finish step
    task automatic wait_compute_done(input int ch);
        int cycles;
        cycles = 0;
        while (!upsampler_stereo_inst.inuse[ch]) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: channel %0d never started computing", ch));
            end
            step_cycle();
            cycles++;
        end
        cycles = 0;
        while (upsampler_stereo_inst.inuse[ch]) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: channel %0d never finished computing", ch));
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic pop_and_check(input logic [1:0] mask, input logic [31:0] expected);
        int cycles;
        out_pop_i = mask;
        step_cycle();
        out_pop_i = '0;
        cycles = 1;
        while (out_ack_o == 2'b00) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("timeout: no ack came back after an output pop");
            end
            step_cycle();
            cycles++;
        end
        check_value("ack latency in cycles", cycles, 2);
        check_value("out_ack_o", out_ack_o, mask);
        check_value("data_o", data_o, expected);
        step_cycle();
        // ack lasts a single cycle
        check_value("out_ack_o one cycle after ack", out_ack_o, 0);
        for (int ch = 0; ch < 2; ch++) begin
            if (mask[ch]) begin
                wait_compute_done(ch);
                pop_count[ch]++;
            end
        end
    endtask

    initial begin
        int base;
        int op;
        int ch;
        int count;
        logic [31:0] value_a;
        logic [31:0] value_b;
        bit done;

        clk = 1'b0;
        rst = 1'b1;
        data_i = '0;
        wr_ack_i = '0;
        out_pop_i = '0;
        pop_count = '{0, 0};
        rd_pop_count = '{0, 0};
        $readmemh("upsampler_tests.txt", test_mem);

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // outputs stay quiet until the first pop
        repeat (4) begin
            step_cycle();
            check_value("out_ack_o while idle", out_ack_o, 0);
            check_value("rd_pop_o while idle", rd_pop_o, 0);
        end

        done = 1'b0;
        for (int line = 0; line < MAX_LINES && !done; line++) begin
            base = line * LINE_WORDS;
            op = test_mem[base];
            ch = test_mem[base+1];
            count = test_mem[base+2];
            value_a = test_mem[base+3];
            value_b = test_mem[base+4];
            case (op)
                OP_END: done = 1'b1;
                OP_WRITE: write_sample(ch, value_a);
                OP_POP: repeat (count) pop_and_check(2'b01 << ch, value_a);
                // both channels ack together onto the OR-merged output bus
                OP_POP_BOTH: repeat (count) pop_and_check(2'b11, value_a | value_b);
                default: abort_run($sformatf("unknown operation %0d in the data file", op));
            endcase
        end

        // one ring buffer pop per completed phase cycle
        for (int c = 0; c < 2; c++) begin
            check_value($sformatf("rd_pop_o pulse count on channel %0d", c),
                        rd_pop_count[c], pop_count[c] / resampler_pkg::NUM_PHASE);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- upsampler_stereo.sv
// stereo 2x polyphase upsampler top, two channels sharing one coefficient ROM and multiplier
`timescale 1ns/100ps

module upsampler_stereo (
    input  logic                               clk,
    input  logic                               rst,
    // producer side
    input  logic [resampler_pkg::SAMPLE_W-1:0] data_i,
    input  logic [1:0]                         wr_ack_i,
    output logic [1:0]                         rd_pop_o,
    // consumer side
    input  logic [1:0]                         out_pop_i,
    output logic [resampler_pkg::SAMPLE_W-1:0] data_o,
    output logic [1:0]                         out_ack_o
);

    logic                                       mult_ready;
    logic [1:0]                                 inuse;
    logic [1:0]                                 grant;
    logic [1:0]                                 rb_pop;
    logic [resampler_pkg::BANK_ADDR_W-1:0]      bank_addr [2];
    logic [resampler_pkg::BANK_ADDR_W-1:0]      bank_addr_bus;
    logic signed [resampler_pkg::COEFF_W-1:0]   bank_data;
    logic signed [resampler_pkg::SAMPLE_W-1:0]  mpcand [2];
    logic signed [resampler_pkg::SAMPLE_W-1:0]  mpcand_bus;
    logic signed [resampler_pkg::COEFF_W-1:0]   mplier [2];
    logic signed [resampler_pkg::COEFF_W-1:0]   mplier_bus;
    logic signed [resampler_pkg::SAMPLE_W-1:0]  mprod;
    logic [resampler_pkg::FIR_DEPTH_LOG2-1:0]   rb_offset [2];
    logic [resampler_pkg::SAMPLE_W-1:0]         rb_data [2];
    logic [resampler_pkg::SAMPLE_W-1:0]         chan_data [2];

    // multiplier is dedicated to this pair
    assign mult_ready = 1'b1;

    // idle channels drive zero, so OR merges the shared buses
    assign bank_addr_bus = bank_addr[0] | bank_addr[1];
    assign mpcand_bus = mpcand[0] | mpcand[1];
    assign mplier_bus = mplier[0] | mplier[1];
    assign data_o = chan_data[0] | chan_data[1];
    assign rd_pop_o = rb_pop;

    fir_coeff_rom u_rom (
        .clk    (clk),
        .addr_i (bank_addr_bus),
        .data_o (bank_data)
    );

    shared_multiplier u_mult (
        .clk      (clk),
        .rst      (rst),
        .mpcand_i (mpcand_bus),
        .mplier_i (mplier_bus),
        .mprod_o  (mprod)
    );

    multiplier_grant u_grant (
        .clk          (clk),
        .rst          (rst),
        .mult_ready_i (mult_ready),
        .pop_i        (out_pop_i),
        .inuse_i      (inuse),
        .grant_o      (grant)
    );

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        sample_ringbuf u_ringbuf (
            .clk      (clk),
            .rst      (rst),
            .data_i   (data_i),
            .we_i     (wr_ack_i[ch]),
            .pop_i    (rb_pop[ch]),
            .offset_i ({{(resampler_pkg::RB_LEN_LOG2 - resampler_pkg::FIR_DEPTH_LOG2){1'b0}},
                        rb_offset[ch]}),
            .data_o   (rb_data[ch])
        );

        polyphase_channel u_chan (
            .clk         (clk),
            .rst         (rst),
            .grant_i     (grant[ch]),
            .inuse_o     (inuse[ch]),
            .bank_addr_o (bank_addr[ch]),
            .bank_data_i (bank_data),
            .mpcand_o    (mpcand[ch]),
            .mplier_o    (mplier[ch]),
            .mprod_i     (mprod),
            .rb_pop_o    (rb_pop[ch]),
            .rb_offset_o (rb_offset[ch]),
            .rb_data_i   (rb_data[ch]),
            .pop_i       (out_pop_i[ch]),
            .data_o      (chan_data[ch]),
            .ack_o       (out_ack_o[ch])
        );
    end

endmodule

//--- multiplier_grant.sv
// arbitration of the shared multiplier between the two channels, channel 0 first on a tie
`timescale 1ns/100ps

module multiplier_grant (
    input  logic       clk,
    input  logic       rst,
    input  logic       mult_ready_i,
    input  logic [1:0] pop_i,
    input  logic [1:0] inuse_i,
    output logic [1:0] grant_o
);

    logic [1:0] waiting_q;
    logic [1:0] inuse_q;
    logic [1:0] inuse_fall;
    logic [1:0] can_grant;

    assign inuse_fall = inuse_q & ~inuse_i;

    // other channel must neither hold a grant nor still be draining the pipe
    assign can_grant[0] = waiting_q[0] && mult_ready_i && !inuse_i[1] && !grant_o[1];
    assign can_grant[1] = waiting_q[1] && mult_ready_i && !inuse_i[0] && !grant_o[0]
                          && !can_grant[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting_q <= '0;
            inuse_q <= '0;
            grant_o <= '0;
        end else begin
            inuse_q <= inuse_i;
            for (int ch = 0; ch < 2; ch++) begin
                if (pop_i[ch]) begin
                    waiting_q[ch] <= 1'b1;
                end
                if (can_grant[ch]) begin
                    waiting_q[ch] <= 1'b0;
                    grant_o[ch] <= 1'b1;
                end else if (inuse_fall[ch]) begin
                    // channel finished its finish step
                    grant_o[ch] <= 1'b0;
                end
            end
        end
    end

    // at most one channel holds or still uses the multiplier at any time
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant_o | inuse_i));

endmodule

//--- polyphase_channel.sv
// one resampler channel FSM: streams eight taps through the shared multiplier, answers pops
`timescale 1ns/100ps

module polyphase_channel (
    input  logic                                        clk,
    input  logic                                        rst,
    // shared multiplier ownership
    input  logic                                        grant_i,
    output logic                                        inuse_o,
    // coefficient rom
    output logic [resampler_pkg::BANK_ADDR_W-1:0]       bank_addr_o,
    input  logic signed [resampler_pkg::COEFF_W-1:0]    bank_data_i,
    // shared multiplier
    output logic signed [resampler_pkg::SAMPLE_W-1:0]   mpcand_o,
    output logic signed [resampler_pkg::COEFF_W-1:0]    mplier_o,
    input  logic signed [resampler_pkg::SAMPLE_W-1:0]   mprod_i,
    // input ring buffer
    output logic                                        rb_pop_o,
    output logic [resampler_pkg::FIR_DEPTH_LOG2-1:0]    rb_offset_o,
    input  logic signed [resampler_pkg::SAMPLE_W-1:0]   rb_data_i,
    // output side
    input  logic                                        pop_i,
    output logic [resampler_pkg::SAMPLE_W-1:0]          data_o,
    output logic                                        ack_o
);

    enum logic [2:0] {
        ST_IDLE,
        ST_RESULT,
        ST_CALC_PENDING,
        ST_CALC,
        ST_NEXT_PHASE
    } state_q;

    logic                                        pop_q;
    // cycle index inside the tap loop, runs past FIR_DEPTH to drain the pipe
    logic [resampler_pkg::FIR_DEPTH_LOG2:0]      cnt_q;
    logic [resampler_pkg::NUM_PHASE_LOG2-1:0]    phase_q;
    logic signed [resampler_pkg::SAMPLE_W-1:0]   mpcand_q;
    logic signed [resampler_pkg::COEFF_W-1:0]    mplier_q;
    logic signed [resampler_pkg::ACC_W-1:0]      sum_q;
    logic signed [resampler_pkg::SAMPLE_W-1:0]   result_q;
    logic signed [resampler_pkg::ACC_W-1:0]      prod_ext;
    logic                                        phase_wrap;
    logic                                        tap_issue;
    logic                                        tap_load;
    logic                                        tap_accum;

    function automatic logic signed [resampler_pkg::SAMPLE_W-1:0] clamp(
        input logic signed [resampler_pkg::ACC_W-1:0] value
    );
        if (value > resampler_pkg::CLAMP_MAX) begin
            return resampler_pkg::CLAMP_MAX[resampler_pkg::SAMPLE_W-1:0];
        end else if (value < resampler_pkg::CLAMP_MIN) begin
            return resampler_pkg::CLAMP_MIN[resampler_pkg::SAMPLE_W-1:0];
        end
        return value[resampler_pkg::SAMPLE_W-1:0];
    endfunction

    // tap k: address at cnt k, operands at k+1, product back at k+PIPE_DEPTH-1
    assign tap_issue = (state_q == ST_CALC) && (cnt_q < resampler_pkg::FIR_DEPTH);
    assign tap_load = (state_q == ST_CALC) && (cnt_q >= 1)
                      && (cnt_q <= resampler_pkg::FIR_DEPTH);
    assign tap_accum = (state_q == ST_CALC)
                       && (cnt_q >= resampler_pkg::PIPE_DEPTH - 1)
                       && (cnt_q < resampler_pkg::PIPE_DEPTH - 1 + resampler_pkg::FIR_DEPTH);

    assign phase_wrap = (phase_q == resampler_pkg::NUM_PHASE - 1);
    assign prod_ext = {{(resampler_pkg::ACC_W - resampler_pkg::SAMPLE_W)
                        {mprod_i[resampler_pkg::SAMPLE_W-1]}}, mprod_i};

    // shared buses stay zero while another channel owns them
    assign bank_addr_o = tap_issue ? {phase_q, cnt_q[resampler_pkg::FIR_DEPTH_LOG2-1:0]} : '0;
    assign mpcand_o = mpcand_q;
    assign mplier_o = mplier_q;
    assign rb_offset_o = cnt_q[resampler_pkg::FIR_DEPTH_LOG2-1:0];
    assign rb_pop_o = (state_q == ST_NEXT_PHASE) && phase_wrap;

    assign inuse_o = (state_q == ST_CALC) || (state_q == ST_NEXT_PHASE);
    // ack returns the previous result while the new one is computed
    assign ack_o = (state_q == ST_RESULT);
    assign data_o = ack_o ? result_q : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            pop_q <= 1'b0;
            cnt_q <= '0;
            phase_q <= '0;
            mpcand_q <= '0;
            mplier_q <= '0;
            result_q <= '0;
        end else begin
            pop_q <= pop_i;

            if (tap_load) begin
                mpcand_q <= rb_data_i;
                mplier_q <= bank_data_i;
            end else begin
                mpcand_q <= '0;
                mplier_q <= '0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (pop_q) begin
                        state_q <= ST_RESULT;
                    end
                end
                ST_RESULT, ST_CALC_PENDING: begin
                    cnt_q <= '0;
                    state_q <= grant_i ? ST_CALC : ST_CALC_PENDING;
                end
                ST_CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == resampler_pkg::FIR_DEPTH + resampler_pkg::PIPE_DEPTH - 1) begin
                        state_q <= ST_NEXT_PHASE;
                    end
                end
                ST_NEXT_PHASE: begin
                    cnt_q <= '0;
                    phase_q <= phase_wrap ? '0 : phase_q + 1'b1;
                    result_q <= clamp(sum_q);
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // accumulator is cleared before every tap loop
    always_ff @(posedge clk) begin
        if (state_q == ST_RESULT) begin
            sum_q <= '0;
        end else if (tap_accum) begin
            sum_q <= sum_q + prod_ext;
        end
    end

    // tap loop only runs while this channel owns the multiplier
    assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_CALC) |-> grant_i);

endmodule

//--- shared_multiplier.sv
// pipelined signed sample by coefficient multiplier shared by both channels, Q15 scaled output
`timescale 1ns/100ps

module shared_multiplier (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic signed [resampler_pkg::SAMPLE_W-1:0] mpcand_i,
    input  logic signed [resampler_pkg::COEFF_W-1:0]  mplier_i,
    output logic signed [resampler_pkg::SAMPLE_W-1:0] mprod_o
);

    logic signed [resampler_pkg::SAMPLE_W-1:0] a_q;
    logic signed [resampler_pkg::COEFF_W-1:0]  b_q;
    logic signed [resampler_pkg::SAMPLE_W+resampler_pkg::COEFF_W-1:0] a_ext;
    logic signed [resampler_pkg::SAMPLE_W+resampler_pkg::COEFF_W-1:0] b_ext;
    logic signed [resampler_pkg::SAMPLE_W+resampler_pkg::COEFF_W-1:0] prod_shift;
    // full width products between multiply and scale stages
    logic signed [resampler_pkg::SAMPLE_W+resampler_pkg::COEFF_W-1:0]
        prod_q [resampler_pkg::MULT_LATENCY-2];

    assign a_ext = {{resampler_pkg::COEFF_W{a_q[resampler_pkg::SAMPLE_W-1]}}, a_q};
    assign b_ext = {{resampler_pkg::SAMPLE_W{b_q[resampler_pkg::COEFF_W-1]}}, b_q};
    assign prod_shift = prod_q[resampler_pkg::MULT_LATENCY-3] >>> resampler_pkg::PROD_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
            for (int i = 0; i < resampler_pkg::MULT_LATENCY - 2; i++) begin
                prod_q[i] <= '0;
            end
            mprod_o <= '0;
        end else begin
            a_q <= mpcand_i;
            b_q <= mplier_i;
            prod_q[0] <= a_ext * b_ext;
            for (int i = 1; i < resampler_pkg::MULT_LATENCY - 2; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
            // scale back to sample width, plain truncation
            mprod_o <= prod_shift[resampler_pkg::SAMPLE_W-1:0];
        end
    end

endmodule

//--- fir_coeff_rom.sv
// coefficient ROM for both polyphase branches, shared by the two channels with one cycle latency
`timescale 1ns/100ps

module fir_coeff_rom (
    input  logic                                     clk,
    input  logic [resampler_pkg::BANK_ADDR_W-1:0]    addr_i,
    output logic signed [resampler_pkg::COEFF_W-1:0] data_o
);

    logic signed [resampler_pkg::COEFF_W-1:0] coeff;

    // two mirror-image branches of a 16-tap interpolation lowpass, Q15
    // each branch sums slightly above unity so full scale saturates
    always_comb begin
        case (addr_i)
            // phase 0, early half sample
            4'd0:    coeff = -16'sd164;
            4'd1:    coeff = 16'sd605;
            4'd2:    coeff = -16'sd1738;
            4'd3:    coeff = 16'sd7372;
            4'd4:    coeff = 16'sd29418;
            4'd5:    coeff = -16'sd3190;
            4'd6:    coeff = 16'sd1003;
            4'd7:    coeff = -16'sd294;
            // phase 1, late half sample
            4'd8:    coeff = -16'sd294;
            4'd9:    coeff = 16'sd1003;
            4'd10:   coeff = -16'sd3190;
            4'd11:   coeff = 16'sd29418;
            4'd12:   coeff = 16'sd7372;
            4'd13:   coeff = -16'sd1738;
            4'd14:   coeff = 16'sd605;
            4'd15:   coeff = -16'sd164;
            default: coeff = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        data_o <= coeff;
    end

endmodule

//--- sample_ringbuf.sv
// per-channel input sample ring buffer, written by the producer and read by offset from its tail
`timescale 1ns/100ps

module sample_ringbuf (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [resampler_pkg::SAMPLE_W-1:0]    data_i,
    input  logic                                  we_i,
    input  logic                                  pop_i,
    input  logic [resampler_pkg::RB_LEN_LOG2-1:0] offset_i,
    output logic [resampler_pkg::SAMPLE_W-1:0]    data_o
);

    logic [resampler_pkg::SAMPLE_W-1:0]    mem [resampler_pkg::RB_LEN];
    // entries never written since reset read back as silence
    logic [resampler_pkg::RB_LEN-1:0]      written_q;
    logic [resampler_pkg::RB_LEN_LOG2-1:0] wr_ptr_q;
    logic [resampler_pkg::RB_LEN_LOG2-1:0] rd_ptr_q;
    logic [resampler_pkg::RB_LEN_LOG2-1:0] rd_addr;

    assign rd_addr = rd_ptr_q + offset_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= resampler_pkg::RB_READ_START[resampler_pkg::RB_LEN_LOG2-1:0];
            rd_ptr_q <= '0;
            written_q <= '0;
        end else begin
            if (we_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                written_q[wr_ptr_q] <= 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + resampler_pkg::DECIM[resampler_pkg::RB_LEN_LOG2-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr_q] <= data_i;
        end
        data_o <= written_q[rd_addr] ? mem[rd_addr] : '0;
    end

    // producer must not lap the oldest sample the channel still reads
    assert property (@(posedge clk) disable iff (rst)
        (we_i && !pop_i) |=> (wr_ptr_q != rd_ptr_q));

endmodule

//--- resampler_pkg.sv
// shared widths, depths and limits for the stereo 2x resampler, referenced by scoped name
package resampler_pkg;

    // audio and coefficient widths
    localparam int SAMPLE_W = 24;
    localparam int COEFF_W = 16;
    // headroom for eight products
    localparam int ACC_W = 26;

    // filter shape
    localparam int FIR_DEPTH = 8;
    localparam int FIR_DEPTH_LOG2 = 3;
    localparam int NUM_PHASE = 2;
    localparam int NUM_PHASE_LOG2 = 1;
    // input samples consumed per phase wrap
    localparam int DECIM = 1;

    // rom address is {phase, tap}
    localparam int BANK_ADDR_W = NUM_PHASE_LOG2 + FIR_DEPTH_LOG2;

    // multiplier stages, then address, operand load and add around it
    localparam int MULT_LATENCY = 4;
    localparam int PIPE_DEPTH = MULT_LATENCY + 3;

    // input ring buffer
    localparam int RB_LEN = 32;
    localparam int RB_LEN_LOG2 = 5;
    // read pointer starts this far behind the write pointer
    localparam int RB_READ_START = 12;

    // coefficients are Q15
    localparam int PROD_SHIFT = 15;

    // output saturation, symmetric around zero
    localparam logic signed [ACC_W-1:0] CLAMP_MAX =
        {{(ACC_W - SAMPLE_W + 1){1'b0}}, {(SAMPLE_W - 1){1'b1}}};
    localparam logic signed [ACC_W-1:0] CLAMP_MIN = -CLAMP_MAX;

endpackage
